// ==== sim.f ====
+incdir+logic
logic/game_pkg.sv
logic/record_pkg.sv
logic/player_hand.sv
logic/round_fsm.sv
logic/winner_judge.sv
logic/score_table.sv
logic/win_blink_timer.sv
logic/blackjack_top.sv
testbench/tb_clock.sv
testbench/blackjack_asserts.sv
testbench/blackjack_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile the design and testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module blackjack_tb -f sim.f \
	--Mdir "$BUILD_DIR" -o blackjack_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator compile failed with status $status"
	exit 1
fi

"./$BUILD_DIR/blackjack_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
	exit 0
fi
echo "pass line not found in $LOG"
exit 1

// ==== testbench/blackjack_tb.sv ====
`timescale 1ns/1ps
`include "blackjack_defines.svh"

module blackjack_tb;
	import game_pkg::*;
	import record_pkg::*;

	logic clk;
	logic reset;
	logic mode_ai;
	logic new_round;
	player_ctrl_t p1_ctrl;
	player_ctrl_t p2_ctrl;
	record_cmd_t record;
	hand_t p1_hand;
	hand_t p2_hand;
	result_t result;
	round_phase_t phase;
	score_t read_data;
	score_t best_score;
	win_leds_t leds;

	int value_errors = 0;
	int other_errors = 0;
	// running maximum of every score that was really saved
	score_t best_model = '0;

	tb_clock #(.PERIOD(20)) u_clock (.clk(clk));

	blackjack_top #(.BLINK_BIT(3)) DUT (
		.clk(clk),
		.reset(reset),
		.mode_ai(mode_ai),
		.new_round(new_round),
		.p1_ctrl(p1_ctrl),
		.p2_ctrl(p2_ctrl),
		.record(record),
		.p1_hand(p1_hand),
		.p2_hand(p2_hand),
		.result(result),
		.phase(phase),
		.read_data(read_data),
		.best_score(best_score),
		.leds(leds)
	);

	task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] want);
		if (got !== want)
		begin
			$display("ERROR %s: got %h expected %h", name, got, want);
			value_errors++;
		end
	endtask

	// settlement worked out from the round rules on the observed hands
	function automatic result_t expected_result(input hand_t h1, input hand_t h2);
		result_t r;
		logic b1;
		logic b2;
		logic t1;
		logic t2;
		logic both;
		b1 = h1.score > `BUST_LIMIT;
		b2 = h2.score > `BUST_LIMIT;
		t1 = h1.score == `BUST_LIMIT;
		t2 = h2.score == `BUST_LIMIT;
		both = h1.stopped && h2.stopped;
		r = '0;
		r.decided = b1 || b2 || t1 || t2 || both;
		if (b1 || b2)
		begin
			r.p1_win = !b1;
			r.p2_win = !b2;
		end
		else if (t1 || t2)
		begin
			r.p1_win = t1;
			r.p2_win = t2;
		end
		else if (both)
		begin
			r.p1_win = h1.score >= h2.score;
			r.p2_win = h2.score >= h1.score;
		end
		if (!b1 && (b2 || h1.score >= h2.score))
			r.top_score = h1.score;
		else if (!b2)
			r.top_score = h2.score;
		return r;
	endfunction

	// the computer dealer holds at the threshold or when it already beats a stopped player 2
	function automatic logic dealer_holds(input hand_t h1, input hand_t h2);
		return (h1.score >= `DEALER_STAND) || (h2.stopped && (h1.score > h2.score));
	endfunction

	// one press by one player, called and left at a falling edge
	task automatic play_step(input int who, input logic is_draw);
		hand_t mine;
		hand_t later;
		result_t model;
		player_ctrl_t press;
		logic open;
		logic want_draw;
		logic want_stand;
		mine = (who == 1) ? p1_hand : p2_hand;
		model = expected_result(p1_hand, p2_hand);
		open = !model.decided && !mine.stopped && (phase == PLAY);
		want_draw = open && is_draw;
		want_stand = open && !is_draw;
		if (mode_ai && (who == 1))
		begin
			// a draw press is a dealer step and a stand press is ignored
			want_stand = open && is_draw && dealer_holds(p1_hand, p2_hand);
			want_draw = open && is_draw && !want_stand;
		end
		press.draw = is_draw;
		press.stand = !is_draw;
		@(posedge clk);
		if (who == 1)
			p1_ctrl <= press;
		else
			p2_ctrl <= press;
		@(posedge clk);
		p1_ctrl <= '0;
		p2_ctrl <= '0;
		@(negedge clk);
		later = (who == 1) ? p1_hand : p2_hand;
		// the command is only registered at this edge, so the hand must not have moved yet
		if (later != mine)
		begin
			$display("player %0d hand changed one cycle too early", who);
			other_errors++;
		end
		@(negedge clk);
		later = (who == 1) ? p1_hand : p2_hand;
		if (want_draw)
		begin
			if ((later.score != mine.score + 8'd1) && (later.score != mine.score + 8'd3))
			begin
				$display("ERROR p%0d_hand.score: got %h expected %h plus 1 or 3",
					who, later.score, mine.score);
				value_errors++;
			end
		end
		else
		begin
			expect_eq($sformatf("p%0d_hand.score", who), later.score, mine.score);
		end
		expect_eq($sformatf("p%0d_hand.stopped", who), later.stopped, mine.stopped || want_stand);
	endtask

	task automatic wait_phase(input round_phase_t want, input int limit);
		int n;
		n = 0;
		while ((phase != want) && (n < limit))
		begin
			@(negedge clk);
			n++;
		end
		if (phase != want)
		begin
			$display("timeout: phase did not reach %s within %0d cycles", want.name(), limit);
			other_errors++;
		end
	endtask

	// random presses until the round settles, bounded by a step count
	task automatic play_round(input int max_steps);
		int steps;
		steps = 0;
		while ((phase != FINISHED) && (steps < max_steps))
		begin
			play_step(($urandom % 2) + 1, ($urandom % 4) != 0);
			steps++;
		end
		if (phase != FINISHED)
		begin
			$display("timeout: round did not finish within %0d presses", max_steps);
			other_errors++;
		end
	endtask

	task automatic check_settlement();
		result_t model;
		int n;
		logic seen1;
		logic seen2;
		model = expected_result(p1_hand, p2_hand);
		expect_eq("result.decided", result.decided, 1'b1);
		expect_eq("result.p1_win", result.p1_win, model.p1_win);
		expect_eq("result.p2_win", result.p2_win, model.p2_win);
		expect_eq("result.top_score", result.top_score, model.top_score);
		n = 0;
		seen1 = 1'b0;
		seen2 = 1'b0;
		// every winner lamp has to come on, and no loser lamp may ever light
		while ((n < 32) && !((seen1 || !model.p1_win) && (seen2 || !model.p2_win)))
		begin
			@(negedge clk);
			seen1 = seen1 || leds.p1;
			seen2 = seen2 || leds.p2;
			if ((leds.p1 && !model.p1_win) || (leds.p2 && !model.p2_win))
			begin
				$display("a lamp lit for a player who did not win");
				other_errors++;
			end
			n++;
		end
		if ((model.p1_win && !seen1) || (model.p2_win && !seen2))
		begin
			$display("timeout: a winner lamp did not light within 32 cycles");
			other_errors++;
		end
	endtask

	task automatic save_and_read(input logic expect_write);
		rec_addr_t addr;
		result_t model;
		addr = rec_addr_t'($urandom);
		model = expected_result(p1_hand, p2_hand);
		@(posedge clk);
		record <= '{save: 1'b1, save_addr: addr, read_addr: addr};
		@(posedge clk);
		record.save <= 1'b0;
		// the write happened at the last edge, the read address is sampled at the next one
		@(posedge clk);
		@(negedge clk);
		if (expect_write)
		begin
			if (model.top_score >= best_model)
				best_model = model.top_score;
			expect_eq("read_data", read_data, model.top_score);
		end
		expect_eq("best_score", best_score, best_model);
	endtask

	task automatic start_round();
		@(posedge clk);
		new_round <= 1'b1;
		@(posedge clk);
		new_round <= 1'b0;
		@(negedge clk);
		wait_phase(PLAY, 4);
		expect_eq("p1_hand", p1_hand, '0);
		expect_eq("p2_hand", p2_hand, '0);
	endtask

	task automatic reset_state_check();
		expect_eq("p1_hand", p1_hand, '0);
		expect_eq("p2_hand", p2_hand, '0);
		expect_eq("phase", phase, PLAY);
		expect_eq("best_score", best_score, '0);
		expect_eq("leds", leds, '0);
	endtask

	// fixed presses, including draws after a stand that must not move the score
	task automatic two_player_play();
		play_step(2, 1'b1);
		play_step(2, 1'b1);
		play_step(1, 1'b1);
		// both hands now hold cards, so a save taken in the open round would lift the best score
		save_and_read(1'b0);
		play_step(2, 1'b0);
		play_step(2, 1'b1);
		play_step(1, 1'b1);
		play_step(1, 1'b0);
		play_step(1, 1'b1);
		wait_phase(FINISHED, 4);
		start_round();
	endtask

	task automatic settle_rounds(input int rounds);
		repeat (rounds)
		begin
			play_round(120);
			check_settlement();
			// late presses in a settled round are dropped
			play_step(1, 1'b1);
			play_step(2, 1'b1);
			save_and_read(1'b1);
			start_round();
		end
	endtask

	initial
	begin
		reset = 1'b0;
		mode_ai = 1'b0;
		new_round = 1'b0;
		p1_ctrl = '0;
		p2_ctrl = '0;
		record = '0;
		void'($urandom(32'hdc28));
		repeat (4) @(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		reset_state_check();
		two_player_play();
		settle_rounds(6);
		@(posedge clk);
		mode_ai <= 1'b1;
		@(negedge clk);
		settle_rounds(4);
		$display("checks done: %0d value errors, %0d other errors", value_errors, other_errors);
		if ((value_errors == 0) && (other_errors == 0))
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== testbench/blackjack_asserts.sv ====
`timescale 1ns/1ps

module blackjack_asserts (
	input logic clk,
	input logic reset,
	input logic new_round,
	input game_pkg::round_phase_t phase,
	input game_pkg::hand_t p1_hand,
	input game_pkg::hand_t p2_hand,
	input game_pkg::result_t result,
	input game_pkg::win_leds_t leds
);
	import game_pkg::*;

	// a lamp stays dark while nobody wins and in the first cycle of a win
	// the blink counter is cleared on every edge without a winner, so each blink starts dark
	lamps_need_winner: assert property (@(posedge clk) disable iff (!reset)
		(!(result.p1_win || result.p2_win) || !$past(result.p1_win || result.p2_win))
		|-> (leds == '0))
		else $error("winner lamp lit without a win in progress");

	// a settled round keeps its hands until a new round is requested
	// the clear lands one edge after new_round is sampled, so the previous pulse is excluded too
	finished_hands_hold: assert property (@(posedge clk) disable iff (!reset)
		((phase == FINISHED) && !new_round && !$past(new_round))
		|=> ($stable(p1_hand) && $stable(p2_hand)))
		else $error("hands changed in a settled round");

	// a score only moves by one card of value 1 or 3, or drops to zero on a clear
	p1_score_step: assert property (@(posedge clk) disable iff (!reset)
		(p1_hand.score != $past(p1_hand.score)) |->
		((p1_hand.score == score_t'($past(p1_hand.score) + 8'd1))
		|| (p1_hand.score == score_t'($past(p1_hand.score) + 8'd3))
		|| (p1_hand.score == '0)))
		else $error("player 1 score jumped by a value no card has");

	p2_score_step: assert property (@(posedge clk) disable iff (!reset)
		(p2_hand.score != $past(p2_hand.score)) |->
		((p2_hand.score == score_t'($past(p2_hand.score) + 8'd1))
		|| (p2_hand.score == score_t'($past(p2_hand.score) + 8'd3))
		|| (p2_hand.score == '0)))
		else $error("player 2 score jumped by a value no card has");

endmodule

bind blackjack_top blackjack_asserts u_asserts (
	.clk(clk),
	.reset(reset),
	.new_round(new_round),
	.phase(phase),
	.p1_hand(p1_hand),
	.p2_hand(p2_hand),
	.result(result),
	.leds(leds)
);

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD = 20
) (
	output logic clk
);
	// free running clock, starts low so the first rising edge is half a period in
	initial
	begin
		clk = 1'b0;
	end

	always #(PERIOD / 2) clk = ~clk;

endmodule

// ==== logic/blackjack_top.sv ====
`timescale 1ns/1ps
`include "blackjack_defines.svh"

module blackjack_top #(
	parameter int BLINK_BIT = `BLINK_BIT_DEFAULT
) (
	input logic clk,
	input logic reset,
	input logic mode_ai,
	input logic new_round,
	input game_pkg::player_ctrl_t p1_ctrl,
	input game_pkg::player_ctrl_t p2_ctrl,
	input record_pkg::record_cmd_t record,
	output game_pkg::hand_t p1_hand,
	output game_pkg::hand_t p2_hand,
	output game_pkg::result_t result,
	output game_pkg::round_phase_t phase,
	output game_pkg::score_t read_data,
	output game_pkg::score_t best_score,
	output game_pkg::win_leds_t leds
);
	import game_pkg::*;

	hand_cmd_t p1_cmd;
	hand_cmd_t p2_cmd;
	logic save_en;

	// the two hands differ only in where their card generators start
	player_hand #(.LFSR_SEED(`LFSR_SEED_P1)) u_p1_hand (
		.clk(clk),
		.reset(reset),
		.cmd(p1_cmd),
		.hand(p1_hand)
	);

	player_hand #(.LFSR_SEED(`LFSR_SEED_P2)) u_p2_hand (
		.clk(clk),
		.reset(reset),
		.cmd(p2_cmd),
		.hand(p2_hand)
	);

	round_fsm u_round_fsm (
		.clk(clk),
		.reset(reset),
		.mode_ai(mode_ai),
		.new_round(new_round),
		.decided(result.decided),
		.p1_ctrl(p1_ctrl),
		.p2_ctrl(p2_ctrl),
		.p1_hand(p1_hand),
		.p2_hand(p2_hand),
		.record_save(record.save),
		.p1_cmd(p1_cmd),
		.p2_cmd(p2_cmd),
		.save_en(save_en),
		.phase(phase)
	);

	// settlement is purely combinational on the registered hands
	winner_judge u_winner_judge (
		.p1_hand(p1_hand),
		.p2_hand(p2_hand),
		.result(result)
	);

	score_table u_score_table (
		.clk(clk),
		.reset(reset),
		.write(save_en),
		.save_addr(record.save_addr),
		.read_addr(record.read_addr),
		.score(result.top_score),
		.read_data(read_data),
		.best_score(best_score)
	);

	win_blink_timer #(.BLINK_BIT(BLINK_BIT)) u_win_blink_timer (
		.clk(clk),
		.reset(reset),
		.result(result),
		.leds(leds)
	);

endmodule

// ==== logic/win_blink_timer.sv ====
`timescale 1ns/1ps
`include "blackjack_defines.svh"

module win_blink_timer #(
	parameter int BLINK_BIT = `BLINK_BIT_DEFAULT
) (
	input logic clk,
	input logic reset,
	input game_pkg::result_t result,
	output game_pkg::win_leds_t leds
);
	logic [BLINK_BIT:0] count;
	logic any_win;

	assign any_win = result.p1_win || result.p2_win;

	// the counter only runs while somebody is winning, so every blink starts dark
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			count <= '0;
		end
		else if (!any_win)
		begin
			count <= '0;
		end
		else
		begin
			count <= count + 1'b1;
		end
	end

	// the top counter bit sets the blink rate
	assign leds.p1 = result.p1_win && count[BLINK_BIT];
	assign leds.p2 = result.p2_win && count[BLINK_BIT];

endmodule

// ==== logic/score_table.sv ====
`timescale 1ns/1ps
`include "blackjack_defines.svh"

module score_table (
	input logic clk,
	input logic reset,
	input logic write,
	input record_pkg::rec_addr_t save_addr,
	input record_pkg::rec_addr_t read_addr,
	input game_pkg::score_t score,
	output game_pkg::score_t read_data,
	output game_pkg::score_t best_score
);
	import game_pkg::*;

	score_t mem [`TABLE_DEPTH];

	// single port write with a registered read, maps onto block RAM
	always_ff @(posedge clk)
	begin
		if (write)
		begin
			mem[save_addr] <= score;
		end
		// reading the address being written returns the old entry
		read_data <= mem[read_addr];
	end

	// best score follows every save that ties or beats it
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			best_score <= '0;
		end
		else if (write && (score >= best_score))
		begin
			best_score <= score;
		end
	end

endmodule

// ==== logic/winner_judge.sv ====
`timescale 1ns/1ps
`include "blackjack_defines.svh"

module winner_judge (
	input game_pkg::hand_t p1_hand,
	input game_pkg::hand_t p2_hand,
	output game_pkg::result_t result
);
	import game_pkg::*;

	score_t s1;
	score_t s2;
	logic bust1;
	logic bust2;
	logic hit1;
	logic hit2;
	logic both_stopped;

	assign s1 = p1_hand.score;
	assign s2 = p2_hand.score;

	// over the limit loses, exactly on the limit wins at once
	assign bust1 = s1 > score_t'(`BUST_LIMIT);
	assign bust2 = s2 > score_t'(`BUST_LIMIT);
	assign hit1 = s1 == score_t'(`BUST_LIMIT);
	assign hit2 = s2 == score_t'(`BUST_LIMIT);
	assign both_stopped = p1_hand.stopped && p2_hand.stopped;

	always_comb
	begin
		result = '0;
		result.decided = bust1 || bust2 || hit1 || hit2 || both_stopped;

		if (bust1 || bust2)
		begin
			// a single bust hands the round to the other player, a double bust to nobody
			result.p1_win = bust2 && !bust1;
			result.p2_win = bust1 && !bust2;
		end
		else if (hit1 || hit2)
		begin
			result.p1_win = hit1;
			result.p2_win = hit2;
		end
		else if (both_stopped)
		begin
			// equal totals light both lamps
			result.p1_win = s1 >= s2;
			result.p2_win = s2 >= s1;
		end

		// the best legal total of the round, what gets saved to the table
		if (!bust1 && !bust2)
		begin
			result.top_score = (s1 > s2) ? s1 : s2;
		end
		else if (!bust1)
		begin
			result.top_score = s1;
		end
		else if (!bust2)
		begin
			result.top_score = s2;
		end
	end

endmodule

// ==== logic/round_fsm.sv ====
`timescale 1ns/1ps
`include "blackjack_defines.svh"

module round_fsm (
	input logic clk,
	input logic reset,
	input logic mode_ai,
	input logic new_round,
	input logic decided,
	input game_pkg::player_ctrl_t p1_ctrl,
	input game_pkg::player_ctrl_t p2_ctrl,
	input game_pkg::hand_t p1_hand,
	input game_pkg::hand_t p2_hand,
	input logic record_save,
	output game_pkg::hand_cmd_t p1_cmd,
	output game_pkg::hand_cmd_t p2_cmd,
	output logic save_en,
	output game_pkg::round_phase_t phase
);
	import game_pkg::*;

	hand_cmd_t p1_next;
	hand_cmd_t p2_next;
	logic p1_live;
	logic p2_live;
	logic dealer_stands;
	logic accept_play;

	// a player counts as stopped as soon as a stand is on its way to the hand
	assign p1_live = !p1_hand.stopped && !p1_cmd.stand;
	assign p2_live = !p2_hand.stopped && !p2_cmd.stand;

	// cards are only dealt while the round is open and not yet settled
	assign accept_play = (phase == PLAY) && !decided;

	// the dealer holds at the threshold, or when it already beats a stopped opponent
	assign dealer_stands = (p1_hand.score >= score_t'(`DEALER_STAND))
		|| (p2_hand.stopped && (p1_hand.score > p2_hand.score));

	// saves only make sense once the round has a final top score
	assign save_en = record_save && (phase == FINISHED);

	always_comb
	begin
		p1_next = '0;
		p2_next = '0;
		if (accept_play)
		begin
			if (mode_ai)
			begin
				// each p1 draw press is one dealer step, the p1 stand button does nothing
				if (p1_ctrl.draw && p1_live)
				begin
					p1_next.stand = dealer_stands;
					p1_next.draw = !dealer_stands;
				end
			end
			else
			begin
				p1_next.draw = p1_ctrl.draw && p1_live;
				p1_next.stand = p1_ctrl.stand && p1_live;
			end
			p2_next.draw = p2_ctrl.draw && p2_live;
			p2_next.stand = p2_ctrl.stand && p2_live;
		end
		else if ((phase == FINISHED) && new_round)
		begin
			p1_next.clear = 1'b1;
			p2_next.clear = 1'b1;
		end
	end

	// commands are registered, so a press sampled at one edge moves the hand at the next
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			p1_cmd <= '0;
			p2_cmd <= '0;
		end
		else
		begin
			p1_cmd <= p1_next;
			p2_cmd <= p2_next;
		end
	end

	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			phase <= PLAY;
		end
		else if ((phase == PLAY) && decided)
		begin
			phase <= FINISHED;
		end
		else if ((phase == FINISHED) && p1_cmd.clear)
		begin
			// reopen together with the edge that empties the hands
			phase <= PLAY;
		end
	end

endmodule

// ==== logic/player_hand.sv ====
`timescale 1ns/1ps
`include "blackjack_defines.svh"

module player_hand #(
	parameter logic [4:0] LFSR_SEED = `LFSR_SEED_P1
) (
	input logic clk,
	input logic reset,
	input game_pkg::hand_cmd_t cmd,
	output game_pkg::hand_t hand
);
	import game_pkg::*;

	logic [4:0] lfsr;
	logic feedback;
	score_t card_value;

	// taps on bits 4 and 1 give a maximal length sequence over five bits
	assign feedback = lfsr[4] ^ lfsr[1];

	// the low bit of the generator picks a small or a large card
	assign card_value = lfsr[0] ? score_t'(3) : score_t'(1);

	// the generator steps every cycle, so the card depends on when the player presses
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			lfsr <= LFSR_SEED;
		end
		else if (lfsr == 5'd0)
		begin
			// the all-zero state would lock up, so restart from the seed
			lfsr <= LFSR_SEED;
		end
		else
		begin
			lfsr <= {lfsr[3:0], feedback};
		end
	end

	// score and stop flag follow the accepted commands one edge later
	always_ff @(posedge clk or negedge reset)
	begin
		if (!reset)
		begin
			hand <= '0;
		end
		else if (cmd.clear)
		begin
			// a new round wipes the total and lets the player draw again
			hand <= '0;
		end
		else
		begin
			if (cmd.draw)
			begin
				hand.score <= hand.score + card_value;
			end
			// once set, the stop flag stays until the next clear
			if (cmd.stand)
			begin
				hand.stopped <= 1'b1;
			end
		end
	end

endmodule

// ==== logic/record_pkg.sv ====
`include "blackjack_defines.svh"

package record_pkg;

	// index into the saved score table
	typedef logic [$clog2(`TABLE_DEPTH)-1:0] rec_addr_t;

	// save request and the two table addresses
	typedef struct packed {
		logic save;
		rec_addr_t save_addr;
		rec_addr_t read_addr;
	} record_cmd_t;

endpackage

// ==== logic/game_pkg.sv ====
`include "blackjack_defines.svh"

package game_pkg;

	// one player's running total
	typedef logic [`SCORE_W-1:0] score_t;

	// what a player has on the table
	typedef struct packed {
		score_t score;
		logic stopped;
	} hand_t;

	// button pulses from a player, one pulse per card or stand
	typedef struct packed {
		logic draw;
		logic stand;
	} player_ctrl_t;

	// accepted commands from the round FSM to one hand
	typedef struct packed {
		logic draw;
		logic stand;
		logic clear;
	} hand_cmd_t;

	// the round is either still open or settled
	typedef enum logic {
		PLAY = 1'b0,
		FINISHED = 1'b1
	} round_phase_t;

	// settlement of the current hands
	typedef struct packed {
		logic p1_win;
		logic p2_win;
		logic decided;
		score_t top_score;
	} result_t;

	// winner lamps, one per player
	typedef struct packed {
		logic p1;
		logic p2;
	} win_leds_t;

endpackage

// ==== logic/blackjack_defines.svh ====
`ifndef BLACKJACK_DEFINES_SVH
`define BLACKJACK_DEFINES_SVH

// width of every score value, big enough to hold a bust hand
`define SCORE_W 8

// a score above this is bust, and a score equal to it wins outright
`define BUST_LIMIT 21

// the computer dealer stops drawing from this score upwards
`define DEALER_STAND 17

// number of saved round scores, the record address is log2 of this
`define TABLE_DEPTH 32

// counter bit that drives the winner lamps on the board clock
`define BLINK_BIT_DEFAULT 22

// starting values of the two card generators, they must not be zero
`define LFSR_SEED_P1 5'b01101
`define LFSR_SEED_P2 5'b10110

`endif
